//--- Bender.yml
package:
  name: sd_axi_writer

sources:
  - source/sd_axi_pkg.sv
  - source/sd_axi_ifs.sv
  - source/halfword_fifo.sv
  - source/wr_addr_track.sv
  - source/axi_single_writer.sv
  - source/sd_axi_top.sv
  - target: simulation
    files:
      - tb/axi_mem_model.sv
      - tb/tb_sd_axi_top.sv

//--- source/axi_single_writer.sv
module axi_single_writer import sd_axi_pkg::*; #(
    parameter int                DATA_WIDTH = 256,
    parameter int                ADDR_WIDTH = 32,
    parameter int                ID_WIDTH   = 8,
    parameter logic [ID_WIDTH-1:0] AXI_ID   = 8'h40
) (
    input  logic                    clk,
    input  logic                    rst_n,
    sample_fifo_if.consumer         src,
    beat_addr_if.consumer           ba,

    output logic [ID_WIDTH-1:0]     model_awid,
    output logic [ADDR_WIDTH-1:0]   model_awaddr,
    output logic [7:0]              model_awlen,
    output logic [2:0]              model_awsize,
    output logic [1:0]              model_awburst,
    output logic                    model_awlock,
    output logic [3:0]              model_awcache,
    output logic [2:0]              model_awprot,
    output logic                    model_awvalid,
    input  logic                    model_awready,
    output logic [DATA_WIDTH-1:0]   model_wdata,
    output logic [DATA_WIDTH/8-1:0] model_wstrb,
    output logic                    model_wlast,
    output logic                    model_wvalid,
    input  logic                    model_wready,
    input  logic [ID_WIDTH-1:0]     model_bid,
    input  logic [1:0]              model_bresp,
    input  logic                    model_bvalid,
    output logic                    model_bready,

    output logic                    ddr_wr_done,
    output logic                    wr_error
);

    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int LANE_W     = $clog2(DATA_WIDTH / SAMPLE_W);
    localparam int SAMPLE_B   = SAMPLE_W / 8;

    wr_state_e         state_q;
    wr_state_e         state_d;
    logic [LANE_W-1:0] lane;
    logic              w_hs;
    logic              b_hs;

    assign model_awid    = AXI_ID;
    assign model_awaddr  = ba.aligned_addr;
    assign model_awlen   = 8'd0;                     // single beat
    assign model_awsize  = 3'($clog2(STRB_WIDTH));   // full bus width
    assign model_awburst = FIXED;
    assign model_awlock  = 1'b0;
    assign model_awcache = 4'b0011;
    assign model_awprot  = 3'b000;

    assign lane        = ba.lane;
    assign model_wdata = {{(DATA_WIDTH-SAMPLE_W){1'b0}}, src.rd_data} << (SAMPLE_W * lane);
    assign model_wstrb = {{(STRB_WIDTH-SAMPLE_B){1'b0}}, {SAMPLE_B{1'b1}}} << (SAMPLE_B * lane);
    assign model_wlast = 1'b1;

    assign w_hs = model_wvalid & model_wready;
    assign b_hs = model_bvalid & model_bready;

    // buffer and address move on together
    assign src.pop    = w_hs;
    assign ba.advance = w_hs;

    always_comb begin
        state_d       = state_q;
        model_awvalid = 1'b0;
        model_wvalid  = 1'b0;
        model_bready  = 1'b0;
        case (state_q)
            IDLE_ADDR: begin
                model_awvalid = ~src.empty;
                if (model_awvalid && model_awready) begin
                    state_d = SEND_DATA;
                end else if (ba.stream_end) begin
                    state_d = FINISHED;
                end
            end
            SEND_DATA: begin
                model_wvalid = 1'b1;
                if (model_wready) begin
                    state_d = WAIT_RESP;
                end
            end
            WAIT_RESP: begin
                model_bready = 1'b1;
                if (model_bvalid) begin
                    state_d = IDLE_ADDR;
                end
            end
            FINISHED: state_d = FINISHED;   // held until reset
            default:  state_d = IDLE_ADDR;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= IDLE_ADDR;
            wr_error <= 1'b0;
        end else begin
            state_q <= state_d;
            if (b_hs && (model_bid != AXI_ID || model_bresp != RESP_OKAY)) begin
                wr_error <= 1'b1;   // sticky, writing goes on
            end
        end
    end

    assign ddr_wr_done = (state_q == FINISHED);

    a_aw_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        model_awvalid && !model_awready |=> model_awvalid && $stable(model_awaddr)
    ) else $error("awvalid or awaddr dropped before awready");

    a_w_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        model_wvalid && !model_wready |=> model_wvalid && $stable(model_wdata)
    ) else $error("wvalid or wdata dropped before wready");

    // response phase opens only right after a data beat
    a_bready_phase: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(model_bready) |-> state_q == WAIT_RESP && $past(w_hs)
    ) else $error("bready outside response phase");

endmodule

//--- source/halfword_fifo.sv
module halfword_fifo import sd_axi_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en,
    input  logic [SAMPLE_W-1:0] wr_sample,
    sample_fifo_if.buffer       rd
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int HALF  = SAMPLE_W / 2;

    logic [SAMPLE_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W:0]      count;
    logic                do_wr;
    logic                do_pop;

    assign rd.empty = (count == '0);
    assign rd.full  = (count == (PTR_W+1)'(FIFO_DEPTH));

    assign do_wr  = wr_en & ~rd.full;
    assign do_pop = rd.pop & ~rd.empty;

    // first arriving byte ends up in the low byte
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= {wr_sample[HALF-1:0], wr_sample[SAMPLE_W-1:HALF]};
        end
    end

    assign rd.rd_data = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps, depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // writer only pops what it has seen on rd_data
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd.pop |-> !rd.empty
    ) else $error("pop while buffer empty");

    // source is expected to honor fifo_full
    a_no_wr_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> !rd.full
    ) else $error("write while buffer full");

endmodule

//--- source/sd_axi_ifs.sv
// sample buffer read side, oldest entry always on rd_data
interface sample_fifo_if #(
    parameter int SAMPLE_W = 16
);
    logic [SAMPLE_W-1:0] rd_data;
    logic                empty;
    logic                full;
    logic                pop;       // only while not empty

    modport buffer (
        output rd_data,
        output empty,
        output full,
        input  pop
    );

    modport consumer (
        input  rd_data,
        input  empty,
        output pop
    );
endinterface

interface beat_addr_if import sd_axi_pkg::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 256
);
    localparam int LANE_W = $clog2(DATA_WIDTH / SAMPLE_W);

    logic [ADDR_WIDTH-1:0] aligned_addr;
    logic [LANE_W-1:0]     lane;        // halfword slot in the bus word
    logic                  advance;     // one-cycle pulse, +2 bytes
    logic                  stream_end;

    modport tracker (
        output aligned_addr,
        output lane,
        output stream_end,
        input  advance
    );

    modport consumer (
        input  aligned_addr,
        input  lane,
        input  stream_end,
        output advance
    );
endinterface

//--- source/sd_axi_pkg.sv
package sd_axi_pkg;

    // one-hot writer states
    typedef enum logic [3:0] {
        IDLE_ADDR = 4'b0001,
        SEND_DATA = 4'b0010,
        WAIT_RESP = 4'b0100,
        FINISHED  = 4'b1000
    } wr_state_e;

    // AXI burst type on awburst
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    // write response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // one sample from the card reader
    localparam int SAMPLE_W = 16;

endpackage

//--- source/sd_axi_top.sv
module sd_axi_top import sd_axi_pkg::*; #(
    parameter int                  DATA_WIDTH = 256,
    parameter int                  ADDR_WIDTH = 32,
    parameter int                  ID_WIDTH   = 8,
    parameter logic [ID_WIDTH-1:0] AXI_ID     = 8'h40,
    parameter int                  FIFO_DEPTH = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  logic [SAMPLE_W-1:0]     wrdata,
    input  logic                    wrlast,
    input  logic [ADDR_WIDTH-1:0]   wr_base_addr,
    output logic                    fifo_full,

    output logic [ID_WIDTH-1:0]     model_awid,
    output logic [ADDR_WIDTH-1:0]   model_awaddr,
    output logic [7:0]              model_awlen,
    output logic [2:0]              model_awsize,
    output logic [1:0]              model_awburst,
    output logic                    model_awlock,
    output logic [3:0]              model_awcache,
    output logic [2:0]              model_awprot,
    output logic                    model_awvalid,
    input  logic                    model_awready,
    output logic [DATA_WIDTH/8-1:0] model_wstrb,
    output logic [DATA_WIDTH-1:0]   model_wdata,
    output logic                    model_wlast,
    output logic                    model_wvalid,
    input  logic                    model_wready,
    input  logic [ID_WIDTH-1:0]     model_bid,
    input  logic [1:0]              model_bresp,
    input  logic                    model_bvalid,
    output logic                    model_bready,

    output logic                    ddr_wr_done,
    output logic                    wr_error
);

    sample_fifo_if #(.SAMPLE_W(SAMPLE_W)) sf_if ();
    beat_addr_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) ba_if ();

    assign fifo_full = sf_if.full;

    halfword_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_sample (wrdata),
        .rd        (sf_if.buffer)
    );

    wr_addr_track #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) u_track (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wrlast       (wrlast),
        .wr_base_addr (wr_base_addr),
        .buf_empty    (sf_if.empty),   // end of stream waits for drain
        .ba           (ba_if.tracker)
    );

    axi_single_writer #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .ID_WIDTH   (ID_WIDTH),
        .AXI_ID     (AXI_ID)
    ) u_writer (
        .clk           (clk),
        .rst_n         (rst_n),
        .src           (sf_if.consumer),
        .ba            (ba_if.consumer),
        .model_awid    (model_awid),
        .model_awaddr  (model_awaddr),
        .model_awlen   (model_awlen),
        .model_awsize  (model_awsize),
        .model_awburst (model_awburst),
        .model_awlock  (model_awlock),
        .model_awcache (model_awcache),
        .model_awprot  (model_awprot),
        .model_awvalid (model_awvalid),
        .model_awready (model_awready),
        .model_wdata   (model_wdata),
        .model_wstrb   (model_wstrb),
        .model_wlast   (model_wlast),
        .model_wvalid  (model_wvalid),
        .model_wready  (model_wready),
        .model_bid     (model_bid),
        .model_bresp   (model_bresp),
        .model_bvalid  (model_bvalid),
        .model_bready  (model_bready),
        .ddr_wr_done   (ddr_wr_done),
        .wr_error      (wr_error)
    );

endmodule

//--- source/wr_addr_track.sv
module wr_addr_track import sd_axi_pkg::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 256
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic                  wrlast,
    input  logic [ADDR_WIDTH-1:0] wr_base_addr,
    input  logic                  buf_empty,
    beat_addr_if.tracker          ba
);

    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int LANE_W     = $clog2(DATA_WIDTH / SAMPLE_W);
    localparam int OFF_W      = $clog2(STRB_WIDTH);
    localparam logic [ADDR_WIDTH-1:0] STEP = ADDR_WIDTH'(SAMPLE_W / 8);

    logic [ADDR_WIDTH-1:0] addr_q;
    logic                  base_loaded;
    logic                  last_seen;
    logic [LANE_W-1:0]     lane;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q      <= '0;
            base_loaded <= 1'b0;
        end else if (wr_en && !base_loaded) begin
            addr_q      <= wr_base_addr;     // first sample of the stream
            base_loaded <= 1'b1;
        end else if (ba.advance) begin
            addr_q      <= addr_q + STEP;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_seen <= 1'b0;
        end else if (wrlast) begin
            last_seen <= 1'b1;
        end
    end

    assign lane            = addr_q[OFF_W-1:1];
    assign ba.lane         = lane;
    assign ba.aligned_addr = {addr_q[ADDR_WIDTH-1:OFF_W], {OFF_W{1'b0}}};

    // end only once everything buffered has gone out
    assign ba.stream_end = last_seen & buf_empty;

    // writer cannot issue a beat before the base is known
    a_adv_after_load: assert property (
        @(posedge clk) disable iff (!rst_n)
        ba.advance |-> base_loaded
    ) else $error("address advance before base load");

endmodule

//--- src.f
source/sd_axi_pkg.sv
source/sd_axi_ifs.sv
source/halfword_fifo.sv
source/wr_addr_track.sv
source/axi_single_writer.sv
source/sd_axi_top.sv
tb/axi_mem_model.sv
tb/tb_sd_axi_top.sv

//--- tb/axi_mem_model.sv
module axi_mem_model import sd_axi_pkg::*; #(
    parameter int DATA_WIDTH = 256,
    parameter int ADDR_WIDTH = 32,
    parameter int ID_WIDTH   = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [ID_WIDTH-1:0]     model_awid,
    input  logic [ADDR_WIDTH-1:0]   model_awaddr,
    input  logic                    model_awvalid,
    output logic                    model_awready,
    input  logic [DATA_WIDTH-1:0]   model_wdata,
    input  logic [DATA_WIDTH/8-1:0] model_wstrb,
    input  logic                    model_wvalid,
    output logic                    model_wready,
    output logic [ID_WIDTH-1:0]     model_bid,
    output logic [1:0]              model_bresp,
    output logic                    model_bvalid,
    input  logic                    model_bready
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int MEM_BYTES  = 1024;
    localparam int MAX_TXN    = 64;

    logic [7:0]            mem [MEM_BYTES];
    logic [1:0]            resp_code [MAX_TXN];
    logic                  bad_id [MAX_TXN];
    int unsigned           dly [MAX_TXN][3];   // aw, w and b extra wait
    logic [ID_WIDTH-1:0]   id_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    int unsigned           phase;              // 0 address, 1 data, 2 response
    int unsigned           cnt;
    int unsigned           txn;
    int unsigned           slot;

    assign slot = txn % MAX_TXN;

    task automatic program_txn(input int idx, input logic [1:0] resp, input logic bad,
                               input int unsigned aw_d, input int unsigned w_d,
                               input int unsigned b_d);
        resp_code[idx] = resp;
        bad_id[idx]    = bad;
        dly[idx][0]    = aw_d;
        dly[idx][1]    = w_d;
        dly[idx][2]    = b_d;
    endtask

    function automatic logic [7:0] peek_byte(input logic [ADDR_WIDTH-1:0] addr);
        return mem[addr % MEM_BYTES];
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            model_awready <= 1'b0;
            model_wready  <= 1'b0;
            model_bvalid  <= 1'b0;
            model_bid     <= '0;
            model_bresp   <= RESP_OKAY;
            phase         <= 0;
            cnt           <= 0;
            txn           <= 0;
            for (int i = 0; i < MEM_BYTES; i++) begin
                mem[i] <= 8'h00;
            end
        end else begin
            case (phase)
                0: begin
                    if (model_awvalid && model_awready) begin
                        model_awready <= 1'b0;
                        id_q          <= model_awid;
                        addr_q        <= model_awaddr;
                        cnt           <= 0;
                        phase         <= 1;
                    end else if (model_awvalid) begin
                        if (cnt >= dly[slot][0]) begin
                            model_awready <= 1'b1;
                        end else begin
                            cnt <= cnt + 1;
                        end
                    end
                end
                1: begin
                    if (model_wvalid && model_wready) begin
                        model_wready <= 1'b0;
                        for (int b = 0; b < STRB_WIDTH; b++) begin
                            if (model_wstrb[b]) begin
                                mem[(addr_q + b) % MEM_BYTES] <= model_wdata[8*b +: 8];
                            end
                        end
                        cnt   <= 0;
                        phase <= 2;
                    end else if (model_wvalid) begin
                        if (cnt >= dly[slot][1]) begin
                            model_wready <= 1'b1;
                        end else begin
                            cnt <= cnt + 1;
                        end
                    end
                end
                2: begin
                    if (model_bvalid && model_bready) begin
                        model_bvalid <= 1'b0;
                        txn          <= txn + 1;
                        cnt          <= 0;
                        phase        <= 0;
                    end else if (!model_bvalid) begin
                        if (cnt >= dly[slot][2]) begin
                            model_bvalid <= 1'b1;
                            model_bresp  <= resp_code[slot];
                            model_bid    <= bad_id[slot] ? ~id_q : id_q;   // corrupted on request
                        end else begin
                            cnt <= cnt + 1;
                        end
                    end
                end
                default: phase <= 0;
            endcase
        end
    end

endmodule

//--- tb/tb_sd_axi_top.sv
module tb_sd_axi_top import sd_axi_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_WIDTH = 256;
    localparam int ADDR_WIDTH = 32;
    localparam int BUS_BYTES  = DATA_WIDTH / 8;
    localparam int NROWS      = 29;
    localparam int TIMEOUT    = 2000;
    localparam logic [ADDR_WIDTH-1:0] BASE = 32'h1000_001C;   // lane wraps after two samples

    logic                  clk, rst_n, wr_en, wrlast, fifo_full, ddr_wr_done, wr_error;
    logic [SAMPLE_W-1:0]   wrdata;
    logic [ADDR_WIDTH-1:0] wr_base_addr, model_awaddr;
    logic [7:0]            model_awid, model_bid, model_awlen;
    logic [2:0]            model_awsize, model_awprot;
    logic [1:0]            model_awburst, model_bresp;
    logic [3:0]            model_awcache;
    logic                  model_awlock, model_awvalid, model_awready;
    logic [DATA_WIDTH-1:0] model_wdata;
    logic [BUS_BYTES-1:0]  model_wstrb;
    logic                  model_wlast, model_wvalid, model_wready, model_bvalid, model_bready;

    // sample [27:12], idle gap [11:8], bresp [5:4], bad bid [1], last of run [0]
    logic [27:0] rows [NROWS];
    int          errors, run_first, run_len, sent_cnt, aw_idx, w_idx, b_idx, t;
    logic        in_run, in_flight, last_given, done_seen, timed_out;
    int unsigned seed_ret;

    sd_axi_top DUT (.*);
    axi_mem_model mem_model (.*);

    always #50 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [255:0] got,
                                   input logic [255:0] exp);
        $display("Mismatch %s got %0h expected %0h at %0t", name, got, exp, $time);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("Error %s at %0t", msg, $time);
        errors++;
    endtask

    always @(posedge clk) begin : bus_monitor
        logic [ADDR_WIDTH-1:0] byte_addr;
        int                    lane;
        logic [15:0]           smp;
        logic [15:0]           exp_half;
        logic [BUS_BYTES-1:0]  exp_strb;
        if (rst_n && in_run) begin
            if (done_seen && !ddr_wr_done) report_error("ddr_wr_done dropped before reset");
            if (ddr_wr_done && (!last_given || b_idx != run_len))
                report_error("ddr_wr_done rose before the last B handshake");
            done_seen = done_seen | ddr_wr_done;
            if (model_awvalid && model_awready) begin
                byte_addr = BASE + ADDR_WIDTH'(2 * aw_idx);
                byte_addr = byte_addr - byte_addr % BUS_BYTES;   // bus aligned
                if (in_flight) report_error("AW issued before the previous B handshake");
                if (aw_idx >= sent_cnt) report_error("AW issued with no sample pending");
                if (model_awaddr != byte_addr) report_mismatch("awaddr", model_awaddr, byte_addr);
                if ({model_awid, model_awlen, model_awburst, model_awsize}
                        != {8'h40, 8'h00, FIXED, 3'd5})
                    report_mismatch("awid/awlen/awburst/awsize",
                                    {model_awid, model_awlen, model_awburst, model_awsize},
                                    {8'h40, 8'h00, FIXED, 3'd5});
                if ({model_awlock, model_awcache, model_awprot} != {1'b0, 4'b0011, 3'b000})
                    report_mismatch("awlock/awcache/awprot",
                                    {model_awlock, model_awcache, model_awprot},
                                    {1'b0, 4'b0011, 3'b000});
                in_flight = 1'b1;
                aw_idx++;
            end
            if (model_wvalid && model_wready) begin
                byte_addr = BASE + ADDR_WIDTH'(2 * w_idx);
                lane      = (byte_addr % BUS_BYTES) / 2;
                smp       = rows[(run_first + w_idx) % NROWS][27:12];
                exp_half  = {smp[7:0], smp[15:8]};   // first byte lands low
                exp_strb  = BUS_BYTES'(2'b11) << (2 * lane);
                if (model_wstrb != exp_strb) report_mismatch("wstrb", model_wstrb, exp_strb);
                if (model_wdata[16*lane +: 16] != exp_half)
                    report_mismatch("wdata lane", model_wdata[16*lane +: 16], exp_half);
                if (model_wlast !== 1'b1) report_mismatch("wlast", model_wlast, 1'b1);
                w_idx++;
            end
            if (model_bvalid && model_bready) begin
                in_flight = 1'b0;
                b_idx++;
            end
        end
    end

    task automatic start_run();
        rst_n      = 1'b0;
        in_run     = 1'b0;
        sent_cnt   = 0;
        aw_idx     = 0;
        w_idx      = 0;
        b_idx      = 0;
        in_flight  = 1'b0;
        last_given = 1'b0;
        done_seen  = 1'b0;
        for (int i = 0; i < run_len; i++) begin
            mem_model.program_txn(i, rows[run_first + i][5:4], rows[run_first + i][1],
                                  $urandom % 4, $urandom % 4, $urandom % 4);
        end
        repeat (2) @(posedge clk);
        #1;
        if ({model_awvalid, model_wvalid, model_bready, ddr_wr_done, wr_error, fifo_full} != 0)
            report_mismatch("awvalid/wvalid/bready/ddr_wr_done/wr_error/fifo_full in reset",
                {model_awvalid, model_wvalid, model_bready, ddr_wr_done, wr_error, fifo_full}, 0);
        rst_n  = 1'b1;
        in_run = 1'b1;
    endtask

    task automatic apply_row(input int r);
        int wait_cnt;
        wr_en  = 1'b0;
        wrlast = 1'b0;
        repeat (rows[r][11:8]) begin
            @(posedge clk);
            #1;
        end
        wait_cnt = 0;
        while (fifo_full && !timed_out) begin
            @(posedge clk);
            #1;
            wait_cnt++;
            if (wait_cnt > TIMEOUT) begin
                $display("Timeout waiting for fifo_full to clear at %0t", $time);
                timed_out = 1'b1;
            end
        end
        if (!timed_out) begin
            wr_en      = 1'b1;
            wrdata     = rows[r][27:12];
            wrlast     = rows[r][0];
            last_given = last_given | rows[r][0];
            sent_cnt++;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_run();
        logic [ADDR_WIDTH-1:0] a;
        logic [15:0]           s;
        logic                  exp_err;
        exp_err = 1'b0;
        for (int i = 0; i < run_len; i++) begin
            a       = BASE + ADDR_WIDTH'(2 * i);
            s       = rows[run_first + i][27:12];
            exp_err = exp_err | (rows[run_first + i][5:4] != RESP_OKAY) | rows[run_first + i][1];
            if (mem_model.peek_byte(a) != s[15:8])
                report_mismatch($sformatf("mem[%0h]", a), mem_model.peek_byte(a), s[15:8]);
            if (mem_model.peek_byte(a + 1) != s[7:0])
                report_mismatch($sformatf("mem[%0h]", a + 1), mem_model.peek_byte(a + 1), s[7:0]);
        end
        if (aw_idx != run_len) report_mismatch("AW count", aw_idx, run_len);
        if (w_idx != run_len) report_mismatch("W count", w_idx, run_len);
        if (b_idx != run_len) report_mismatch("B count", b_idx, run_len);
        if (wr_error !== exp_err) report_mismatch("wr_error", wr_error, exp_err);
        if (ddr_wr_done !== 1'b1) report_mismatch("ddr_wr_done", ddr_wr_done, 1'b1);
    endtask

    initial begin
        seed_ret     = $urandom(32'h2d6edf10);
        clk          = 1'b0;
        rst_n        = 1'b0;
        wr_en        = 1'b0;
        wrdata       = '0;
        wrlast       = 1'b0;
        wr_base_addr = BASE;
        errors       = 0;
        timed_out    = 1'b0;
        in_run       = 1'b0;
        rows = '{28'hA1B2_1_0_0, 28'hC3D4_0_0_0, 28'h0F1E_3_0_0,
                 28'h5566_0_0_0, 28'h7788_2_0_0, 28'h99AA_0_0_1,    // okay only
                 28'h1357_0_0_0, 28'h2468_0_0_2, 28'hBEEF_1_0_1,    // bad bid
                 28'hCAFE_0_0_0, 28'hF00D_0_0_0, 28'h0123_0_2_0,    // slverr
                 28'h4567_0_0_0, 28'h89AB_0_0_0, 28'hCDEF_0_0_0,
                 28'h3C3C_0_0_0, 28'h5A5A_0_0_0, 28'hA5A5_0_0_0,
                 28'h1111_0_0_0, 28'h2222_0_0_0, 28'h3333_0_0_0,
                 28'h4444_0_0_0, 28'h5555_0_0_0, 28'h6666_0_0_0,
                 28'h7777_0_0_0, 28'h9999_0_0_0, 28'hAAAA_0_0_0,
                 28'hBBBB_0_0_0, 28'h8888_2_0_1};
        run_first = 0;
        while (run_first < NROWS && !timed_out) begin
            run_len = 1;
            while (!rows[run_first + run_len - 1][0]) run_len++;
            start_run();
            for (int r = run_first; r < run_first + run_len; r++) begin
                if (!timed_out) apply_row(r);
            end
            wr_en  = 1'b0;
            wrlast = 1'b0;
            t      = 0;
            while (!ddr_wr_done && !timed_out) begin
                @(posedge clk);
                #1;
                t++;
                if (t > TIMEOUT) begin
                    $display("Timeout waiting for ddr_wr_done at %0t", $time);
                    timed_out = 1'b1;
                end
            end
            repeat (3) @(posedge clk);   // done has to hold
            #1;
            if (!timed_out) check_run();
            run_first += run_len;
        end
        $display("Errors: %0d, timeouts: %0d", errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
